/* Makefile */
TOP = tb_miss_handler

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
hw/miss_cfg_pkg.sv
hw/miss_types_pkg.sv
hw/miss_fifo.sv
hw/miss_req_sender.sv
hw/refill_buffer.sv
hw/refill_ctrl.sv
hw/miss_handler.sv
sim/tb_miss_handler.sv

/* hw/miss_cfg_pkg.sv */
// Sizes shared by the miss handler and its testbench
// A line is NLINE_WIDTH + CL_OFFSET_WIDTH address bits, and one beat is one cache access
`default_nettype none

package miss_cfg_pkg;

    // Cache organisation
    localparam int unsigned NUM_BANKS       = 2;
    localparam int unsigned BANK_ID_WIDTH   = 1;
    localparam int unsigned MSHR_ID_WIDTH   = 3;
    localparam int unsigned NLINE_WIDTH     = 26;
    localparam int unsigned CL_OFFSET_WIDTH = 6;

    // Memory interface
    localparam int unsigned MEM_ADDR_WIDTH = NLINE_WIDTH + CL_OFFSET_WIDTH;
    localparam int unsigned MEM_DATA_WIDTH = 64;
    localparam int unsigned MEM_ID_WIDTH   = BANK_ID_WIDTH + MSHR_ID_WIDTH;
    localparam int unsigned MEM_LEN_WIDTH  = 8;

    // Refill sizing, 64-byte line of 64-bit beats
    localparam int unsigned DEFAULT_CL_BEATS        = 8;
    localparam int unsigned WORD_IDX_WIDTH          = 8;
    localparam int unsigned DEFAULT_RESP_FIFO_DEPTH = 2;

endpackage

`default_nettype wire

/* hw/miss_fifo.sv */
// Register FIFO, the writer must respect wok_o and the reader rok_o
// With FeedThrough a full FIFO accepts a write in the cycle it is popped
`timescale 1ns/1ps
`default_nettype none

module miss_fifo #(
    parameter int unsigned Depth       = 2,
    parameter bit          FeedThrough = 1'b0,
    parameter type         data_t      = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic w_i,
    output logic      wok_o,
    input  data_t     wdata_i,
    input  wire logic r_i,
    output logic      rok_o,
    output data_t     rdata_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    data_t               mem_q [Depth];
    logic [PtrWidth-1:0] wptr_q, rptr_q;
    logic [CntWidth-1:0] cnt_q;
    logic                full;

    assign full    = (cnt_q == CntWidth'(Depth));
    assign rok_o   = (cnt_q != '0);
    assign wok_o   = !full || (FeedThrough && r_i);
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (w_i) begin
                wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (r_i) begin
                rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
            end
            case ({w_i, r_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_i) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_i |-> wok_o)
        else $error("write into a full FIFO");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_i |-> rok_o)
        else $error("read from an empty FIFO");

endmodule

`default_nettype wire

/* hw/miss_handler.sv */
// Miss handler top, memory beats must match the cache access width
// refill_req_valid_o is a level request, a bank grants by raising its ready
`timescale 1ns/1ps
`default_nettype none

module miss_handler
    import miss_cfg_pkg::*;
    import miss_types_pkg::*;
#(
    parameter int unsigned ClBeats       = DEFAULT_CL_BEATS,
    parameter int unsigned RespFifoDepth = DEFAULT_RESP_FIFO_DEPTH
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    // Bank miss requests
    input  wire logic [NUM_BANKS-1:0] miss_req_valid_i,
    output logic      [NUM_BANKS-1:0] miss_req_ready_o,
    input  miss_req_t [NUM_BANKS-1:0] miss_req_i,
    // Memory
    output logic                      mem_req_valid_o,
    input  wire logic                 mem_req_ready_i,
    output mem_req_t                  mem_req_o,
    input  wire logic                 mem_resp_valid_i,
    output logic                      mem_resp_ready_o,
    input  mem_resp_t                 mem_resp_i,
    // Bank refill and MSHR acknowledge
    output logic [NUM_BANKS-1:0]      refill_req_valid_o,
    input  wire logic [NUM_BANKS-1:0] refill_req_ready_i,
    output logic [NUM_BANKS-1:0]      refill_busy_o,
    output logic [NUM_BANKS-1:0]      refill_write_data_o,
    output logic [NUM_BANKS-1:0]      refill_write_dir_o,
    output refill_wr_t                refill_wr_o,
    output logic                      refill_is_error_o,
    output logic [NUM_BANKS-1:0]      mshr_ack_o,
    output logic [MSHR_ID_WIDTH-1:0]  mshr_ack_id_o
);

    logic                      meta_rok;
    resp_meta_t                meta;
    logic                      pop_meta;
    logic [MEM_DATA_WIDTH-1:0] data;
    logic                      pop_data;

    miss_req_sender #(
        .ClBeats (ClBeats)
    ) req_sender_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .miss_req_valid_i (miss_req_valid_i),
        .miss_req_ready_o (miss_req_ready_o),
        .miss_req_i       (miss_req_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o)
    );

    refill_buffer #(
        .ClBeats       (ClBeats),
        .RespFifoDepth (RespFifoDepth)
    ) refill_buffer_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_i       (mem_resp_i),
        .meta_rok_o       (meta_rok),
        .meta_o           (meta),
        .pop_meta_i       (pop_meta),
        .data_o           (data),
        .pop_data_i       (pop_data)
    );

    refill_ctrl #(
        .ClBeats (ClBeats)
    ) refill_ctrl_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .meta_rok_i          (meta_rok),
        .meta_i              (meta),
        .pop_meta_o          (pop_meta),
        .data_i              (data),
        .pop_data_o          (pop_data),
        .refill_req_valid_o  (refill_req_valid_o),
        .refill_req_ready_i  (refill_req_ready_i),
        .refill_busy_o       (refill_busy_o),
        .refill_write_data_o (refill_write_data_o),
        .refill_write_dir_o  (refill_write_dir_o),
        .refill_wr_o         (refill_wr_o),
        .refill_is_error_o   (refill_is_error_o),
        .mshr_ack_o          (mshr_ack_o),
        .mshr_ack_id_o       (mshr_ack_id_o)
    );

endmodule

`default_nettype wire

/* hw/miss_req_sender.sv */
// One read per missed line, ID is {bank, mshr}, only one request waits in the send stage
// Each bank has a two-entry buffer, so a bank can post again while its miss is queued
`timescale 1ns/1ps
`default_nettype none

module miss_req_sender
    import miss_cfg_pkg::*;
    import miss_types_pkg::*;
#(
    parameter int unsigned ClBeats = DEFAULT_CL_BEATS
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic [NUM_BANKS-1:0] miss_req_valid_i,
    output logic      [NUM_BANKS-1:0] miss_req_ready_o,
    input  miss_req_t [NUM_BANKS-1:0] miss_req_i,
    output logic                      mem_req_valid_o,
    input  wire logic                 mem_req_ready_i,
    output mem_req_t                  mem_req_o
);

    localparam logic [MEM_LEN_WIDTH-1:0] ReqLen = MEM_LEN_WIDTH'(ClBeats - 1);

    send_state_e               state_q, state_d;
    miss_req_t [NUM_BANKS-1:0] fifo_rdata;
    logic      [NUM_BANKS-1:0] fifo_rok;
    logic      [NUM_BANKS-1:0] fifo_r;
    logic                      gnt_valid;
    logic [BANK_ID_WIDTH-1:0]  gnt_id;
    logic [BANK_ID_WIDTH-1:0]  last_q;
    logic [NLINE_WIDTH-1:0]    nline_q;
    logic [MEM_ID_WIDTH-1:0]   id_q;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_buf
        miss_fifo #(
            .Depth       (2),
            .FeedThrough (1'b1),
            .data_t      (miss_req_t)
        ) bank_buf_i (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .w_i     (miss_req_valid_i[b] & miss_req_ready_o[b]),
            .wok_o   (miss_req_ready_o[b]),
            .wdata_i (miss_req_i[b]),
            .r_i     (fifo_r[b]),
            .rok_o   (fifo_rok[b]),
            .rdata_o (fifo_rdata[b])
        );
    end

    // Round robin, search starts just after the last granted bank
    always_comb begin : arb_comb
        int idx;
        gnt_valid = 1'b0;
        gnt_id    = '0;
        for (int i = int'(NUM_BANKS); i >= 1; i--) begin
            idx = (int'(last_q) + i) % int'(NUM_BANKS);
            if (fifo_rok[idx]) begin
                gnt_valid = 1'b1;
                gnt_id    = BANK_ID_WIDTH'(idx);
            end
        end
        fifo_r = '0;
        if (state_q == SND_IDLE && gnt_valid) begin
            fifo_r[gnt_id] = 1'b1;
        end
    end

    always_comb begin
        state_d         = state_q;
        mem_req_valid_o = 1'b0;
        unique case (state_q)
            SND_IDLE: begin
                if (gnt_valid) begin
                    state_d = SND_SEND;
                end
            end
            SND_SEND: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = SND_IDLE;
                end
            end
            default: state_d = SND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SND_IDLE;
            last_q  <= '0;
        end else begin
            state_q <= state_d;
            if (|fifo_r) begin
                last_q <= gnt_id;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (|fifo_r) begin
            nline_q <= fifo_rdata[gnt_id].nline;
            id_q    <= {gnt_id, fifo_rdata[gnt_id].mshr_id};
        end
    end

    assign mem_req_o.addr = {nline_q, {CL_OFFSET_WIDTH{1'b0}}};
    assign mem_req_o.len  = ReqLen;
    assign mem_req_o.id   = id_q;
    assign mem_req_o.cmd  = MEM_READ;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else $error("memory request changed under back-pressure");

endmodule

`default_nettype wire

/* hw/miss_types_pkg.sv */
// Structs and FSM encodings passed between the miss handler blocks
// The memory ID is always the bank number above the MSHR identifier
`default_nettype none

package miss_types_pkg;

    import miss_cfg_pkg::*;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_e;

    typedef struct packed {
        logic [NLINE_WIDTH-1:0]   nline;
        logic [MSHR_ID_WIDTH-1:0] mshr_id;
    } miss_req_t;

    typedef struct packed {
        logic [MEM_ADDR_WIDTH-1:0] addr;
        // Number of beats minus one
        logic [MEM_LEN_WIDTH-1:0]  len;
        logic [MEM_ID_WIDTH-1:0]   id;
        mem_cmd_e                  cmd;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_DATA_WIDTH-1:0] data;
        logic [MEM_ID_WIDTH-1:0]   id;
        logic                      error;
        logic                      last;
    } mem_resp_t;

    typedef struct packed {
        logic [MEM_ID_WIDTH-1:0] id;
        logic                    error;
    } resp_meta_t;

    typedef struct packed {
        logic [MEM_DATA_WIDTH-1:0] data;
        logic [WORD_IDX_WIDTH-1:0] word_idx;
    } refill_wr_t;

    typedef enum logic {
        SND_IDLE = 1'b0,
        SND_SEND = 1'b1
    } send_state_e;

    typedef enum logic {
        RFL_IDLE  = 1'b0,
        RFL_WRITE = 1'b1
    } refill_state_e;

endpackage

`default_nettype wire

/* hw/refill_buffer.sv */
// Holds up to RespFifoDepth complete responses, beats and per-line metadata apart
// Metadata is written with the last beat, so meta_rok_o means the whole line is here
`timescale 1ns/1ps
`default_nettype none

module refill_buffer
    import miss_cfg_pkg::*;
    import miss_types_pkg::*;
#(
    parameter int unsigned ClBeats       = DEFAULT_CL_BEATS,
    parameter int unsigned RespFifoDepth = DEFAULT_RESP_FIFO_DEPTH
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 mem_resp_valid_i,
    output logic                      mem_resp_ready_o,
    input  mem_resp_t                 mem_resp_i,
    output logic                      meta_rok_o,
    output resp_meta_t                meta_o,
    input  wire logic                 pop_meta_i,
    output logic [MEM_DATA_WIDTH-1:0] data_o,
    input  wire logic                 pop_data_i
);

    logic       data_w, data_wok, data_rok;
    logic       meta_w, meta_wok;
    resp_meta_t meta_wdata;

    // The last beat needs room in both FIFOs
    assign mem_resp_ready_o = data_wok && (meta_wok || !mem_resp_i.last);
    assign data_w           = mem_resp_valid_i && mem_resp_ready_o;
    assign meta_w           = data_w && mem_resp_i.last;

    assign meta_wdata.id    = mem_resp_i.id;
    assign meta_wdata.error = mem_resp_i.error;

    miss_fifo #(
        .Depth       (RespFifoDepth),
        .FeedThrough (1'b0),
        .data_t      (resp_meta_t)
    ) meta_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wok_o   (meta_wok),
        .wdata_i (meta_wdata),
        .r_i     (pop_meta_i),
        .rok_o   (meta_rok_o),
        .rdata_o (meta_o)
    );

    miss_fifo #(
        .Depth       (ClBeats * RespFifoDepth),
        .FeedThrough (1'b0),
        .data_t      (logic [MEM_DATA_WIDTH-1:0])
    ) data_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (data_w),
        .wok_o   (data_wok),
        .wdata_i (mem_resp_i.data),
        .r_i     (pop_data_i),
        .rok_o   (data_rok),
        .rdata_o (data_o)
    );

    // Beats of a line stay queued until the refill has consumed them
    a_meta_has_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        meta_rok_o && !pop_meta_i |-> data_rok)
        else $error("line metadata buffered without its data");

endmodule

`default_nettype wire

/* hw/refill_ctrl.sv */
// Refills one buffered line at a time into the bank named by the response ID
// Lines of fewer than two beats are not supported
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl
    import miss_cfg_pkg::*;
    import miss_types_pkg::*;
#(
    parameter int unsigned ClBeats = DEFAULT_CL_BEATS
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      meta_rok_i,
    input  resp_meta_t                     meta_i,
    output logic                           pop_meta_o,
    input  wire logic [MEM_DATA_WIDTH-1:0] data_i,
    output logic                           pop_data_o,
    output logic [NUM_BANKS-1:0]           refill_req_valid_o,
    input  wire logic [NUM_BANKS-1:0]      refill_req_ready_i,
    output logic [NUM_BANKS-1:0]           refill_busy_o,
    output logic [NUM_BANKS-1:0]           refill_write_data_o,
    output logic [NUM_BANKS-1:0]           refill_write_dir_o,
    output refill_wr_t                     refill_wr_o,
    output logic                           refill_is_error_o,
    output logic [NUM_BANKS-1:0]           mshr_ack_o,
    output logic [MSHR_ID_WIDTH-1:0]       mshr_ack_id_o
);

    localparam logic [WORD_IDX_WIDTH-1:0] LastWord = WORD_IDX_WIDTH'(ClBeats - 1);

    refill_state_e             state_q, state_d;
    logic [WORD_IDX_WIDTH-1:0] cnt_q, cnt_d;
    logic [BANK_ID_WIDTH-1:0]  bank_id;

    // Upper ID bits select the bank, the rest is the MSHR entry
    assign bank_id           = meta_i.id[MEM_ID_WIDTH-1 -: BANK_ID_WIDTH];
    assign mshr_ack_id_o     = meta_i.id[MSHR_ID_WIDTH-1:0];
    assign refill_is_error_o = meta_i.error;

    assign refill_wr_o.data     = data_i;
    assign refill_wr_o.word_idx = cnt_q;

    always_comb begin
        state_d             = state_q;
        cnt_d               = cnt_q;
        refill_req_valid_o  = '0;
        refill_write_data_o = '0;
        refill_write_dir_o  = '0;
        mshr_ack_o          = '0;
        pop_meta_o          = 1'b0;
        pop_data_o          = 1'b0;
        unique case (state_q)
            RFL_IDLE: begin
                if (meta_rok_i) begin
                    refill_req_valid_o[bank_id] = 1'b1;
                    if (refill_req_ready_i[bank_id]) begin
                        mshr_ack_o[bank_id] = 1'b1;
                        cnt_d               = '0;
                        state_d             = RFL_WRITE;
                    end
                end
            end
            RFL_WRITE: begin
                // Error lines walk the same sequence without strobing data
                refill_write_data_o[bank_id] = !meta_i.error;
                pop_data_o                   = 1'b1;
                cnt_d                        = cnt_q + 1'b1;
                if (cnt_q == LastWord) begin
                    refill_write_dir_o[bank_id] = 1'b1;
                    pop_meta_o                  = 1'b1;
                    state_d                     = RFL_IDLE;
                end
            end
            default: state_d = RFL_IDLE;
        endcase
    end

    always_comb begin
        refill_busy_o = '0;
        if (state_q == RFL_WRITE) begin
            refill_busy_o[bank_id] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RFL_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    a_min_beats: assert property (@(posedge clk_i) ClBeats >= 2)
        else $error("a line needs at least two beats");

    // The line stays owned by its metadata entry for the whole write burst
    a_pop_in_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_data_o |-> state_q == RFL_WRITE && meta_rok_i)
        else $error("refill data popped outside a line write");

endmodule

`default_nettype wire

/* sim/tb_miss_handler.sv */
// Testbench for the miss handler, memory answers reads in order with one line each
// Misses with MSHR id 5 or 7 get an error response from the memory model
`timescale 1ns/1ps
`default_nettype none

module tb_miss_handler
    import miss_cfg_pkg::*;
    import miss_types_pkg::*;
;

    localparam int unsigned ClBeats  = DEFAULT_CL_BEATS;
    localparam int unsigned MaxLines = 64;
    // About 31 lines of roughly 20 cycles each, plus stalls, fits well below this
    localparam int unsigned TimeoutCycles = 3000;

    logic                      clk_i;
    logic                      rst_ni;
    logic      [NUM_BANKS-1:0] miss_req_valid_i;
    logic      [NUM_BANKS-1:0] miss_req_ready_o;
    miss_req_t [NUM_BANKS-1:0] miss_req_i;
    logic                      mem_req_valid_o;
    logic                      mem_req_ready_i;
    mem_req_t                  mem_req_o;
    logic                      mem_resp_valid_i;
    logic                      mem_resp_ready_o;
    mem_resp_t                 mem_resp_i;
    logic [NUM_BANKS-1:0]      refill_req_valid_o;
    logic [NUM_BANKS-1:0]      refill_req_ready_i;
    logic [NUM_BANKS-1:0]      refill_busy_o;
    logic [NUM_BANKS-1:0]      refill_write_data_o;
    logic [NUM_BANKS-1:0]      refill_write_dir_o;
    refill_wr_t                refill_wr_o;
    logic                      refill_is_error_o;
    logic [NUM_BANKS-1:0]      mshr_ack_o;
    logic [MSHR_ID_WIDTH-1:0]  mshr_ack_id_o;

    integer seed = 8;
    int     err_cnt = 0;
    int     posted = 0;
    int     dir_cnt = 0;
    int     meta_cnt = 0;
    int     cycles = 0;
    bit     stall = 1'b0;

    // Expected lines, in the order memory accepted the reads
    logic [NLINE_WIDTH-1:0]    nline_tab [2**MEM_ID_WIDTH];
    logic [MEM_ID_WIDTH-1:0]   line_id   [MaxLines];
    logic                      line_err  [MaxLines];
    logic [MEM_DATA_WIDTH-1:0] line_data [MaxLines][ClBeats];
    int push_idx = 0;
    int resp_idx = 0;
    int ack_idx = 0;
    int wr_idx = 0;

    // Refill monitor state for the current cycle
    logic                      in_wr;
    logic [WORD_IDX_WIDTH-1:0] beat_cnt;
    int                        pend [NUM_BANKS];
    logic                      last_bank;
    logic                      alt_expect;
    logic [NUM_BANKS-1:0]      req_exp;

    miss_handler miss_handler_i (.*);

    always #20 clk_i = ~clk_i;

    function automatic logic [NUM_BANKS-1:0] bank_mask(input logic [MEM_ID_WIDTH-1:0] id);
        return NUM_BANKS'(1) << id[MEM_ID_WIDTH-1];
    endfunction

    // A complete line not yet acknowledged asks its bank for a refill
    assign req_exp = (!in_wr && meta_cnt > ack_idx) ? bank_mask(line_id[ack_idx]) : '0;

    // Memory read accept, ready may stall at random
    always @(posedge clk_i) begin
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            line_id[push_idx]  = mem_req_o.id;
            line_err[push_idx] = mem_req_o.id[2] & mem_req_o.id[0];
            for (int b = 0; b < ClBeats; b++) begin
                line_data[push_idx][b] = {mem_req_o.addr, 8'(b), 24'({$random(seed)})};
            end
            push_idx++;
        end
        #2;
        mem_req_ready_i = stall ? ({$random(seed)} % 3 != 0) : 1'b1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            refill_req_ready_i[b] = ({$random(seed)} % 3) == 0;
        end
    end

    // Memory response beats, ID and error only on the last one
    always begin : mem_resp_model
        bit sent;
        if (!(resp_idx < push_idx)) begin
            wait (resp_idx < push_idx);
            #2;
        end
        for (int b = 0; b < ClBeats; b++) begin
            sent = 1'b0;
            while (!sent) begin
                mem_resp_valid_i = stall ? ({$random(seed)} % 2 == 0) : 1'b1;
                mem_resp_i.data  = line_data[resp_idx][b];
                mem_resp_i.last  = (b == ClBeats - 1);
                mem_resp_i.id    = mem_resp_i.last ? line_id[resp_idx] : '0;
                mem_resp_i.error = mem_resp_i.last ? line_err[resp_idx] : 1'b0;
                @(posedge clk_i);
                sent = mem_resp_valid_i && mem_resp_ready_o;
                #2;
            end
        end
        mem_resp_valid_i = 1'b0;
        resp_idx++;
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_wr      <= 1'b0;
            beat_cnt   <= '0;
            last_bank  <= 1'b0;
            alt_expect <= 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                pend[b] <= 0;
            end
        end else begin
            cycles <= cycles + 1;
            if (mshr_ack_o != '0) begin
                wr_idx   <= ack_idx;
                ack_idx  <= ack_idx + 1;
                in_wr    <= 1'b1;
                beat_cnt <= '0;
            end else if (in_wr) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == WORD_IDX_WIDTH'(ClBeats - 1)) begin
                    in_wr <= 1'b0;
                end
            end
            if (mem_resp_valid_i && mem_resp_ready_o && mem_resp_i.last) begin
                meta_cnt <= meta_cnt + 1;
            end
            if (refill_write_dir_o != '0) begin
                dir_cnt <= dir_cnt + 1;
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                pend[b] <= pend[b] + int'(miss_req_valid_i[b] & miss_req_ready_o[b])
                    - int'(mem_req_valid_o && mem_req_ready_i
                           && mem_req_o.id[MEM_ID_WIDTH-1] == b);
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                last_bank  <= mem_req_o.id[MEM_ID_WIDTH-1];
                alt_expect <= (pend[!mem_req_o.id[MEM_ID_WIDTH-1]]
                    + int'(miss_req_valid_i[!mem_req_o.id[MEM_ID_WIDTH-1]]
                           & miss_req_ready_o[!mem_req_o.id[MEM_ID_WIDTH-1]])) > 0;
            end
        end
    end

    a_req_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> mem_req_o.addr == {nline_tab[mem_req_o.id], 6'b0})
        else begin
            err_cnt++;
            $display("error %0t: mem_req_o.addr = %h, expected %h", $time,
                mem_req_o.addr, {nline_tab[mem_req_o.id], 6'b0});
        end

    a_req_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> mem_req_o.len == MEM_LEN_WIDTH'(ClBeats - 1))
        else begin
            err_cnt++;
            $display("error %0t: mem_req_o.len = %0d, expected %0d", $time,
                mem_req_o.len, ClBeats - 1);
        end

    a_req_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> mem_req_o.cmd == MEM_READ)
        else begin
            err_cnt++;
            $display("error %0t: mem_req_o.cmd = %0d, expected %0d", $time,
                mem_req_o.cmd, MEM_READ);
        end

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            err_cnt++;
            $display("memory request dropped or changed while stalled at %0t", $time);
        end

    a_req_alternate: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i && alt_expect
        |-> mem_req_o.id[MEM_ID_WIDTH-1] != last_bank)
        else begin
            err_cnt++;
            $display("error %0t: mem_req_o.id bank = %0d, expected %0d", $time,
                mem_req_o.id[MEM_ID_WIDTH-1], !last_bank);
        end

    a_refill_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_req_valid_o == req_exp)
        else begin
            err_cnt++;
            $display("error %0t: refill_req_valid_o = %b, expected %b", $time,
                refill_req_valid_o, req_exp);
        end

    a_ack_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mshr_ack_o == (req_exp & refill_req_ready_i))
        else begin
            err_cnt++;
            $display("error %0t: mshr_ack_o = %b, expected %b", $time,
                mshr_ack_o, req_exp & refill_req_ready_i);
        end

    a_ack_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mshr_ack_o != '0 |-> mshr_ack_o == bank_mask(line_id[ack_idx]))
        else begin
            err_cnt++;
            $display("error %0t: mshr_ack_o = %b, expected %b", $time,
                mshr_ack_o, bank_mask(line_id[ack_idx]));
        end

    a_ack_mshr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mshr_ack_o != '0 |-> mshr_ack_id_o == line_id[ack_idx][MSHR_ID_WIDTH-1:0])
        else begin
            err_cnt++;
            $display("error %0t: mshr_ack_id_o = %0d, expected %0d", $time,
                mshr_ack_id_o, line_id[ack_idx][MSHR_ID_WIDTH-1:0]);
        end

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_busy_o == (in_wr ? bank_mask(line_id[wr_idx]) : '0))
        else begin
            err_cnt++;
            $display("error %0t: refill_busy_o = %b, expected %b", $time,
                refill_busy_o, in_wr ? bank_mask(line_id[wr_idx]) : '0);
        end

    a_word_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_wr |-> refill_wr_o.word_idx == beat_cnt)
        else begin
            err_cnt++;
            $display("error %0t: refill_wr_o.word_idx = %0d, expected %0d", $time,
                refill_wr_o.word_idx, beat_cnt);
        end

    a_wr_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_wr |-> refill_wr_o.data == line_data[wr_idx][beat_cnt])
        else begin
            err_cnt++;
            $display("error %0t: refill_wr_o.data = %h, expected %h", $time,
                refill_wr_o.data, line_data[wr_idx][beat_cnt]);
        end

    a_data_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_write_data_o == ((in_wr && !line_err[wr_idx]) ? bank_mask(line_id[wr_idx]) : '0))
        else begin
            err_cnt++;
            $display("error %0t: refill_write_data_o = %b, expected %b", $time,
                refill_write_data_o,
                (in_wr && !line_err[wr_idx]) ? bank_mask(line_id[wr_idx]) : '0);
        end

    a_is_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_wr |-> refill_is_error_o == line_err[wr_idx])
        else begin
            err_cnt++;
            $display("error %0t: refill_is_error_o = %b, expected %b", $time,
                refill_is_error_o, line_err[wr_idx]);
        end

    a_dir: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_write_dir_o == ((in_wr && beat_cnt == WORD_IDX_WIDTH'(ClBeats - 1))
            ? bank_mask(line_id[wr_idx]) : '0))
        else begin
            err_cnt++;
            $display("error %0t: refill_write_dir_o = %b, expected %b", $time,
                refill_write_dir_o,
                (in_wr && beat_cnt == WORD_IDX_WIDTH'(ClBeats - 1))
                    ? bank_mask(line_id[wr_idx]) : '0);
        end

    task automatic post_miss(input int bank, input int nline, input int mshr);
        nline_tab[{bank[0], mshr[2:0]}] = NLINE_WIDTH'(nline);
        miss_req_i[bank].nline   = NLINE_WIDTH'(nline);
        miss_req_i[bank].mshr_id = MSHR_ID_WIDTH'(mshr);
        miss_req_valid_i[bank]   = 1'b1;
        @(posedge clk_i);
        while (!miss_req_ready_o[bank]) begin
            @(posedge clk_i);
        end
        #2;
        miss_req_valid_i[bank] = 1'b0;
        posted++;
    endtask

    task automatic wait_refills();
        while (dir_cnt != posted) begin
            @(posedge clk_i);
        end
        #2;
    endtask

    task automatic report(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
    endtask

    always @(posedge clk_i) begin
        if (cycles >= TimeoutCycles) begin
            $display("timeout after %0d cycles, %0d of %0d refills done",
                cycles, dir_cnt, posted);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int e;
        clk_i              = 1'b0;
        rst_ni             = 1'b0;
        miss_req_valid_i   = '0;
        miss_req_i         = '0;
        mem_req_ready_i    = 1'b1;
        mem_resp_valid_i   = 1'b0;
        mem_resp_i         = '0;
        refill_req_ready_i = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        e = err_cnt;
        for (int k = 0; k < 3; k++) begin
            post_miss(0, 'h12_3400 + k, k % 4);
        end
        wait_refills();
        report(1, "single bank", e);

        e = err_cnt;
        for (int k = 0; k < 4; k++) begin
            fork
                post_miss(0, 'h20_0000 + k, k % 4);
                post_miss(1, 'h3f_0000 + k, k % 4);
            join
        end
        wait_refills();
        report(2, "both banks", e);

        e = err_cnt;
        fork
            post_miss(0, 'h05_5555, 5);
            post_miss(1, 'h07_7777, 7);
        join
        fork
            post_miss(1, 'h01_1111, 5);
            post_miss(0, 'h02_2222, 7);
        join
        wait_refills();
        report(3, "error responses", e);

        e = err_cnt;
        stall = 1'b1;
        for (int k = 0; k < 8; k++) begin
            fork
                post_miss(0, {$random(seed)} % (2**NLINE_WIDTH), k % 4);
                post_miss(1, {$random(seed)} % (2**NLINE_WIDTH), k % 4);
            join
        end
        wait_refills();
        stall = 1'b0;
        report(4, "random stalls", e);

        $display("%0d refills of %0d misses, %0d errors", dir_cnt, posted, err_cnt);
        if (err_cnt == 0 && dir_cnt == posted) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
